// File: hdl/hd44780_timing_pkg.sv
/*
 * HD44780 bus timing package
 *  data bus and byte widths for the 4-bit interface
 *  default E pulse timing in clocks, sized for a 6 MHz clock
 */

package hd44780_timing_pkg;

    // ******************************
    // bus widths
    // ******************************
    localparam int NYBBLE_W = 4;          // DB7..DB4 only, 4-bit mode
    localparam int BYTE_W   = 8;          // one LCD command or data byte

    // ******************************
    // short bus delays, in clocks
    // ******************************

    // rs and data valid before E rises (tAS, 40 ns min)
    localparam int DEF_TICKS_TAS   = 1;

    // E high width (PWEH, 230 ns min)
    localparam int DEF_TICKS_PWEH  = 3;

    // E rise to the earliest next E rise (tcycE, 500 ns min)
    // must stay above the E high width
    localparam int DEF_TICKS_TCYCE = 6;

endpackage

// File: hdl/hd44780_board_pkg.sv
/*
 * board package
 *  external LED count, alive blinker and PWM defaults
 *  the byte and register select sent once the button arms the design
 */

package hd44780_board_pkg;

    // ******************************
    // alive LEDs
    // ******************************
    localparam int NUM_EXT_LEDS   = 4;     // active low, pin sinks the cathode
    localparam int DEF_BLINK_BITS = 22;    // blink period of about 0.7 s at 6 MHz

    // RGB lit only when the low PWM bits of the counter are all ones
    // so 3 bits gives a 1/8 duty dim
    localparam int DEF_PWM_BITS   = 3;

    // ******************************
    // test transfer
    // ******************************

    // ascii 'G', two easy nybbles to spot on the analyzer
    localparam logic [hd44780_timing_pkg::BYTE_W-1:0] DEF_TEST_BYTE = 8'h47;

    localparam logic DEF_TEST_RS = 1'b1;   // 1 = data register, 0 = command

endpackage

// File: hdl/hd44780_nybble_sender.sv
/*
 * HD44780 nybble sender
 *  puts rs and one nybble on the LCD bus per strobe
 *  then one E pulse of fixed width, and a cycle hold before busy drops
 */
`timescale 1ns/1ps

module hd44780_nybble_sender #(
    parameter int TICKS_TAS   = hd44780_timing_pkg::DEF_TICKS_TAS,
    parameter int TICKS_PWEH  = hd44780_timing_pkg::DEF_TICKS_PWEH,
    parameter int TICKS_TCYCE = hd44780_timing_pkg::DEF_TICKS_TCYCE
) (
    input  logic                                    clk,
    input  logic                                    i_rst,
    input  logic                                    i_stb,       // one cycle, ignored while busy
    input  logic                                    i_rs,
    input  logic [hd44780_timing_pkg::NYBBLE_W-1:0] i_nybble,
    output logic                                    o_busy,
    output logic                                    o_lcd_rs,    // R/W tied low on the board
    output logic                                    o_lcd_e,
    output logic [hd44780_timing_pkg::NYBBLE_W-1:0] o_lcd_data   // to DB7..DB4
);

    // counter only has to hold the longest reload value
    localparam int MAX_AB    = (TICKS_TAS > TICKS_PWEH) ? TICKS_TAS : TICKS_PWEH;
    localparam int MAX_TICKS = (MAX_AB > TICKS_TCYCE) ? MAX_AB : TICKS_TCYCE;
    localparam int CNT_W     = $clog2(MAX_TICKS + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SETUP = 2'd1;   // rs/data on the pins, E low
    localparam logic [1:0] ST_EHIGH = 2'd2;
    localparam logic [1:0] ST_HOLD  = 2'd3;   // E low again, rest of tcycE

    logic [1:0]       state;
    logic [CNT_W-1:0] tick_cnt;               // counts down to zero in every state
    logic             cnt_done;

    assign cnt_done = (tick_cnt == '0);
    assign o_busy   = (state != ST_IDLE);     // rises on the edge that takes the strobe

    // ******************************
    // FSM and pin registers
    // ******************************
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= ST_IDLE;
            tick_cnt   <= '0;
            o_lcd_e    <= 1'b0;
            o_lcd_rs   <= 1'b0;
            o_lcd_data <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_stb) begin
                        o_lcd_rs   <= i_rs;           // held until the next strobe
                        o_lcd_data <= i_nybble;
                        tick_cnt   <= CNT_W'(TICKS_TAS - 1);
                        state      <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    if (cnt_done) begin
                        o_lcd_e  <= 1'b1;             // TICKS_TAS after the strobe edge
                        tick_cnt <= CNT_W'(TICKS_PWEH - 1);
                        state    <= ST_EHIGH;
                    end else begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end
                end
                ST_EHIGH: begin
                    if (cnt_done) begin
                        o_lcd_e  <= 1'b0;             // LCD latches on this falling edge
                        tick_cnt <= CNT_W'(TICKS_TCYCE - TICKS_PWEH - 1);
                        state    <= ST_HOLD;
                    end else begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end
                end
                default: begin                        // ST_HOLD
                    if (cnt_done) begin
                        state <= ST_IDLE;             // TICKS_TCYCE after E rose
                    end else begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // ******************************
    // checks
    // ******************************
    a_e_inside_busy : assert property (@(posedge clk) disable iff (i_rst)
        o_lcd_e |-> o_busy);

    // exact PWEH on the pin, no stretch and no glitch
    a_e_width : assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_lcd_e) |-> o_lcd_e [*TICKS_PWEH] ##1 !o_lcd_e);

endmodule

// File: hdl/hd44780_bytesender.sv
/*
 * HD44780 byte sender
 *  latches a byte and sends it as two nybble transfers, high first
 *  busy covers both transfers with no gap
 */
`timescale 1ns/1ps

module hd44780_bytesender #(
    parameter int TICKS_TAS   = hd44780_timing_pkg::DEF_TICKS_TAS,
    parameter int TICKS_PWEH  = hd44780_timing_pkg::DEF_TICKS_PWEH,
    parameter int TICKS_TCYCE = hd44780_timing_pkg::DEF_TICKS_TCYCE
) (
    input  logic                                    clk,
    input  logic                                    i_rst,
    input  logic                                    i_stb,      // one cycle pulse
    input  logic                                    i_rs,
    input  logic [hd44780_timing_pkg::BYTE_W-1:0]   i_byte,
    output logic                                    o_busy,
    output logic                                    o_lcd_rs,
    output logic                                    o_lcd_e,
    output logic [hd44780_timing_pkg::NYBBLE_W-1:0] o_lcd_data
);

    localparam int NW = hd44780_timing_pkg::NYBBLE_W;

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_HI_STB  = 3'd1;   // strobe high nybble
    localparam logic [2:0] ST_HI_WAIT = 3'd2;
    localparam logic [2:0] ST_LO_STB  = 3'd3;   // strobe low nybble
    localparam logic [2:0] ST_LO_WAIT = 3'd4;

    logic [2:0]                              state;
    logic [hd44780_timing_pkg::BYTE_W-1:0]   byte_q;    // byte of the accepted strobe
    logic                                    rs_q;
    logic                                    ns_stb;
    logic                                    ns_busy;
    logic [NW-1:0]                           ns_nybble;

    assign o_busy    = (state != ST_IDLE);
    assign ns_stb    = (state == ST_HI_STB) || (state == ST_LO_STB);
    assign ns_nybble = (state == ST_HI_STB) ? byte_q[2*NW-1:NW] : byte_q[NW-1:0];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_stb) begin
                        state <= ST_HI_STB;
                    end
                end
                ST_HI_STB:  state <= ST_HI_WAIT;
                ST_HI_WAIT: begin
                    if (!ns_busy) begin         // high nybble done incl. cycle hold
                        state <= ST_LO_STB;
                    end
                end
                ST_LO_STB:  state <= ST_LO_WAIT;
                ST_LO_WAIT: begin
                    if (!ns_busy) begin
                        state <= ST_IDLE;       // end of byte, busy falls here
                    end
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // latch byte and rs with the accepted strobe only
    always_ff @(posedge clk) begin
        if (i_stb && !o_busy) begin
            byte_q <= i_byte;
            rs_q   <= i_rs;
        end
    end

    hd44780_nybble_sender #(
        .TICKS_TAS   (TICKS_TAS),
        .TICKS_PWEH  (TICKS_PWEH),
        .TICKS_TCYCE (TICKS_TCYCE)
    ) u_nybble_sender (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_stb      (ns_stb),
        .i_rs       (rs_q),
        .i_nybble   (ns_nybble),
        .o_busy     (ns_busy),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_e    (o_lcd_e),
        .o_lcd_data (o_lcd_data)
    );

    // high nybble finishing chains straight into the low one with busy held
    a_no_gap : assert property (@(posedge clk) disable iff (i_rst)
        $fell(ns_busy) && (state == ST_HI_WAIT) |=> ns_stb && o_busy);

endmodule

// File: hdl/lcd_send_sequencer.sv
/*
 * LCD send sequencer
 *  button synchronizer and sticky arm latch, analyzer strobe
 *  LCD reset extension, one-shot FSM that sends the test byte
 */
`timescale 1ns/1ps

module lcd_send_sequencer #(
    parameter logic [hd44780_timing_pkg::BYTE_W-1:0] TEST_BYTE =
        hd44780_board_pkg::DEF_TEST_BYTE,
    parameter logic TEST_RS = hd44780_board_pkg::DEF_TEST_RS
) (
    input  logic                                  clk,
    input  logic                                  i_rst,
    input  logic                                  i_button_n,   // async, bouncy, active low
    input  logic                                  i_busy,
    output logic                                  o_armed,
    output logic                                  o_la_strobe,
    output logic                                  o_lcd_rst,
    output logic                                  o_stb,
    output logic                                  o_rs,
    output logic [hd44780_timing_pkg::BYTE_W-1:0] o_byte
);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_LOAD      = 2'd1;
    localparam logic [1:0] ST_WAIT_BUSY = 2'd2;
    localparam logic [1:0] ST_LOCKUP    = 2'd3;

    logic [1:0] btn_sync;     // [1] is the settled sample
    logic       armed_q;
    logic [1:0] state;
    logic       stb_seen;

    // first low sample arms for good, bounces after that do nothing
    always_ff @(posedge clk) begin
        if (i_rst) begin
            btn_sync <= 2'b11;    // released
            armed_q  <= 1'b0;
        end else begin
            btn_sync <= {btn_sync[0], i_button_n};
            if (!btn_sync[1]) begin
                armed_q <= 1'b1;
            end
        end
    end

    assign o_armed     = armed_q;
    assign o_la_strobe = armed_q;              // analyzer triggers on its rising edge
    assign o_lcd_rst   = i_rst | ~armed_q;     // LCD path held until armed

    assign o_stb  = (state == ST_LOAD);
    assign o_rs   = TEST_RS;
    assign o_byte = TEST_BYTE;

    // ******************************
    // one-shot send
    // ******************************
    always_ff @(posedge clk) begin
        if (o_lcd_rst) begin
            state    <= ST_IDLE;
            stb_seen <= 1'b0;
        end else begin
            if (o_stb) begin
                stb_seen <= 1'b1;
            end
            case (state)
                ST_IDLE:      state <= ST_LOAD;       // one idle cycle after arming
                ST_LOAD:      state <= ST_WAIT_BUSY;  // strobe is high in this state
                ST_WAIT_BUSY: begin
                    if (!i_busy) begin                // busy already up from the strobe edge
                        state <= ST_LOCKUP;
                    end
                end
                default:      state <= ST_LOCKUP;     // stays here until reset
            endcase
        end
    end

    a_one_strobe : assert property (@(posedge clk) disable iff (o_lcd_rst)
        o_stb |-> !stb_seen ##1 !o_stb);

endmodule

// File: hdl/alive_blinker.sv
/*
 * alive blinker
 *  free-running blink counter from reset
 *  PWM-dimmed RGB outputs, external active-low LEDs dark until armed
 */
`timescale 1ns/1ps

module alive_blinker #(
    parameter int BLINK_BITS = hd44780_board_pkg::DEF_BLINK_BITS,   // at least 4
    parameter int PWM_BITS   = hd44780_board_pkg::DEF_PWM_BITS
) (
    input  logic                                        clk,
    input  logic                                        i_rst,
    input  logic                                        i_armed,
    output logic                                        o_led_r,      // active high
    output logic                                        o_led_g,
    output logic                                        o_led_b,
    output logic [hd44780_board_pkg::NUM_EXT_LEDS-1:0] o_ext_led_n   // active low
);

    localparam int T = BLINK_BITS - 1;    // top bit, half the blink period

    logic [BLINK_BITS-1:0] blink_cnt;
    logic                  pwm_on;        // 1 of every 2**PWM_BITS cycles

    assign pwm_on = &blink_cnt[PWM_BITS-1:0];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            blink_cnt <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    // ******************************
    // RGB, one stage behind count
    // ******************************
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_led_r <= 1'b0;
            o_led_g <= 1'b0;
            o_led_b <= 1'b0;
        end else begin
            o_led_g <= pwm_on & ~blink_cnt[T];       // green and blue alternate
            o_led_b <= pwm_on &  blink_cnt[T];
            o_led_r <= pwm_on & ~blink_cnt[T-1];     // red at twice the rate
        end
    end

    // external LEDs, all off (high) while unarmed
    always_ff @(posedge clk) begin
        if (i_rst || !i_armed) begin
            o_ext_led_n <= '1;
        end else begin
            o_ext_led_n[0] <=  blink_cnt[T-1];
            o_ext_led_n[1] <= ~blink_cnt[T-2];
            o_ext_led_n[2] <=  blink_cnt[T-2];
            o_ext_led_n[3] <= ~blink_cnt[T-3];
        end
    end

endmodule

// File: hdl/hd44780_top.sv
/*
 * HD44780 byte-sender top level
 *  button arms the sequencer, which sends one byte over the 4-bit bus
 *  alive blinker on the RGB and external LEDs
 */
`timescale 1ns/1ps

module hd44780_top #(
    // LCD bus timing in clocks
    parameter int TICKS_TAS   = hd44780_timing_pkg::DEF_TICKS_TAS,
    parameter int TICKS_PWEH  = hd44780_timing_pkg::DEF_TICKS_PWEH,
    parameter int TICKS_TCYCE = hd44780_timing_pkg::DEF_TICKS_TCYCE,
    // blinker
    parameter int BLINK_BITS  = hd44780_board_pkg::DEF_BLINK_BITS,
    parameter int PWM_BITS    = hd44780_board_pkg::DEF_PWM_BITS,
    // what gets sent after the press
    parameter logic [hd44780_timing_pkg::BYTE_W-1:0] TEST_BYTE =
        hd44780_board_pkg::DEF_TEST_BYTE,
    parameter logic TEST_RS = hd44780_board_pkg::DEF_TEST_RS
) (
    input  logic                                        clk,
    input  logic                                        i_rst,
    input  logic                                        i_button_n,   // pulled up, low = pressed
    output logic                                        o_lcd_rs,
    output logic                                        o_lcd_e,
    output logic [hd44780_timing_pkg::NYBBLE_W-1:0]     o_lcd_data,
    output logic                                        o_led_r,
    output logic                                        o_led_g,
    output logic                                        o_led_b,
    output logic [hd44780_board_pkg::NUM_EXT_LEDS-1:0] o_ext_led_n,
    output logic                                        o_la_strobe   // analyzer trigger
);

    logic                                  armed;
    logic                                  lcd_rst;     // i_rst extended until armed
    logic                                  seq_stb;
    logic                                  seq_rs;
    logic [hd44780_timing_pkg::BYTE_W-1:0] seq_byte;
    logic                                  bs_busy;

    // ******************************
    // button and send control
    // ******************************
    lcd_send_sequencer #(
        .TEST_BYTE (TEST_BYTE),
        .TEST_RS   (TEST_RS)
    ) u_sequencer (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_button_n  (i_button_n),
        .i_busy      (bs_busy),
        .o_armed     (armed),
        .o_la_strobe (o_la_strobe),
        .o_lcd_rst   (lcd_rst),
        .o_stb       (seq_stb),
        .o_rs        (seq_rs),
        .o_byte      (seq_byte)
    );

    // LCD side
    hd44780_bytesender #(
        .TICKS_TAS   (TICKS_TAS),
        .TICKS_PWEH  (TICKS_PWEH),
        .TICKS_TCYCE (TICKS_TCYCE)
    ) u_bytesender (
        .clk        (clk),
        .i_rst      (lcd_rst),
        .i_stb      (seq_stb),
        .i_rs       (seq_rs),
        .i_byte     (seq_byte),
        .o_busy     (bs_busy),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_e    (o_lcd_e),
        .o_lcd_data (o_lcd_data)
    );

    // runs from reset, not from arming
    alive_blinker #(
        .BLINK_BITS (BLINK_BITS),
        .PWM_BITS   (PWM_BITS)
    ) u_blinker (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_armed     (armed),
        .o_led_r     (o_led_r),
        .o_led_g     (o_led_g),
        .o_led_b     (o_led_b),
        .o_ext_led_n (o_ext_led_n)
    );

endmodule

// File: tb/tb_hd44780_top.sv
/*
 * testbench for the HD44780 byte-sender top level
 *  table of button rows, LCD bus monitor on every E pulse
 *  model of the blinker and arm latch, checked every cycle
 */
`timescale 1ns/1ps

module tb_hd44780_top;

    localparam int   TICKS_TAS   = 1;
    localparam int   TICKS_PWEH  = 3;
    localparam int   TICKS_TCYCE = 6;
    localparam int   BLINK_BITS  = 8;
    localparam int   PWM_BITS    = 2;
    localparam logic [7:0] TEST_BYTE = 8'h47;
    localparam logic TEST_RS     = 1'b1;
    localparam int   T           = BLINK_BITS - 1;
    localparam int   NLED        = hd44780_board_pkg::NUM_EXT_LEDS;
    localparam int   WINDOW      = 60;    // cycles watched after the button release
    localparam int   N_ROWS      = 5;

    // ******************************
    // stimulus table
    // ******************************
    string row_name   [N_ROWS] = '{"clean_press", "bouncy_press", "long_hold",
                                   "reset_midrow", "after_reset"};
    int    row_delay  [N_ROWS] = '{5, 12, 3, 7, 9};     // reset release to press
    int    row_bounce [N_ROWS] = '{0, 3, 1, 2, 0};      // glitches before steady low
    int    row_hold   [N_ROWS] = '{4, 10, 50, 6, 2};    // steady low, then release
    int    row_rst_at [N_ROWS] = '{0, 0, 0, 40, 0};     // window cycle of a reset, 0 none

    logic clk = 1'b0;
    logic rst;
    logic btn_n;
    logic o_lcd_rs;
    logic o_lcd_e;
    logic o_led_r;
    logic o_led_g;
    logic o_led_b;
    logic o_la_strobe;
    logic [hd44780_timing_pkg::NYBBLE_W-1:0] o_lcd_data;
    logic [NLED-1:0]                         o_ext_led_n;

    int          val_errors   = 0;
    int          other_errors = 0;
    int          cycle_limit  = 0;
    int          run_cycles   = 0;
    string       cur_name     = "reset";
    logic [31:0] lfsr         = 32'he873fcc4;

    always #50 clk = ~clk;                    // 100 ns period

    hd44780_top #(
        .TICKS_TAS   (TICKS_TAS),
        .TICKS_PWEH  (TICKS_PWEH),
        .TICKS_TCYCE (TICKS_TCYCE),
        .BLINK_BITS  (BLINK_BITS),
        .PWM_BITS    (PWM_BITS),
        .TEST_BYTE   (TEST_BYTE),
        .TEST_RS     (TEST_RS)
    ) u_dut (
        .clk         (clk),
        .i_rst       (rst),
        .i_button_n  (btn_n),
        .o_lcd_rs    (o_lcd_rs),
        .o_lcd_e     (o_lcd_e),
        .o_lcd_data  (o_lcd_data),
        .o_led_r     (o_led_r),
        .o_led_g     (o_led_g),
        .o_led_b     (o_led_b),
        .o_ext_led_n (o_ext_led_n),
        .o_la_strobe (o_la_strobe)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    // one LFSR step per bit taken
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        val_errors++;
        $display("FAILED %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
    endtask

    task automatic step();
        @(posedge clk);
        #2;                                   // inputs move just after the edge
    endtask

    // ******************************
    // model of arm latch and blinker
    // ******************************
    logic [BLINK_BITS-1:0] m_cnt = '0;
    logic       s1 = 1'b1;                  // button seen through two flops
    logic       s2 = 1'b1;
    logic       exp_armed = 1'b0;
    logic       exp_r = 1'b0;
    logic       exp_g = 1'b0;
    logic       exp_b = 1'b0;
    logic [NLED-1:0] exp_ext = '1;
    logic       pwm_on;

    assign pwm_on = &m_cnt[PWM_BITS-1:0];

    always @(posedge clk) begin
        if (rst) begin
            m_cnt     <= '0;
            s1        <= 1'b1;
            s2        <= 1'b1;
            exp_armed <= 1'b0;
            {exp_r, exp_g, exp_b} <= 3'b000;
            exp_ext   <= '1;
        end else begin
            m_cnt <= m_cnt + 1'b1;
            s1    <= btn_n;
            s2    <= s1;
            if (!s2) exp_armed <= 1'b1;       // sticky until reset
            exp_g <= pwm_on & ~m_cnt[T];
            exp_b <= pwm_on & m_cnt[T];
            exp_r <= pwm_on & ~m_cnt[T-1];
            exp_ext <= exp_armed ? {~m_cnt[T-3], m_cnt[T-2], ~m_cnt[T-2], m_cnt[T-1]} : '1;
        end
    end

    // outputs against the model on every falling edge
    always @(negedge clk) begin
        if ({o_led_r, o_led_g, o_led_b} !== {exp_r, exp_g, exp_b})
            report_value("rgb", {exp_r, exp_g, exp_b}, {o_led_r, o_led_g, o_led_b});
        if (o_ext_led_n !== exp_ext) report_value("ext leds", exp_ext, o_ext_led_n);
        if (o_la_strobe !== exp_armed) report_value("la strobe", exp_armed, o_la_strobe);
        if (!exp_armed && o_lcd_e !== 1'b0) begin
            other_errors++;
            $display("%s: E went high while the design was not armed", cur_name);
        end
    end

    // ******************************
    // LCD bus monitor
    // ******************************
    logic [3:0] rise_data [$];
    logic       rise_rs   [$];
    logic       e_prev    = 1'b0;
    bit         rise_seen = 1'b0;
    int         mon_cyc   = 0;
    int         last_rise = 0;
    int         e_width   = 0;

    always @(negedge clk) begin
        mon_cyc++;
        if (o_lcd_e && !e_prev) begin
            if (rise_seen && (mon_cyc - last_rise) < TICKS_TCYCE) begin
                other_errors++;
                $display("%s: E rose again only %0d cycles after the last rise",
                         cur_name, mon_cyc - last_rise);
            end
            rise_seen = 1'b1;
            last_rise = mon_cyc;
            e_width   = 1;
            rise_data.push_back(o_lcd_data);
            rise_rs.push_back(o_lcd_rs);
        end else if (o_lcd_e) begin
            e_width++;
        end else if (e_prev && e_width != TICKS_PWEH) begin
            report_value("E high width", TICKS_PWEH, e_width);
        end
        e_prev = o_lcd_e;
    end

    task automatic check_reset_values();
        if ({o_lcd_e, o_lcd_rs, o_lcd_data} !== '0)
            report_value("lcd pins after reset", 0, {o_lcd_e, o_lcd_rs, o_lcd_data});
        if ({o_la_strobe, o_led_r, o_led_g, o_led_b} !== 4'b0000)
            report_value("strobe and rgb after reset", 0,
                         {o_la_strobe, o_led_r, o_led_g, o_led_b});
        if (o_ext_led_n !== {NLED{1'b1}})
            report_value("ext leds after reset", {NLED{1'b1}}, o_ext_led_n);
    endtask

    task automatic run_row(input int r);
        int         blen;
        logic [3:0] exp_nyb;
        cur_name = row_name[r];
        rst      = 1'b1;
        btn_n    = 1'b1;
        rise_data.delete();
        rise_rs.delete();
        rise_seen = 1'b0;
        repeat (8) step();
        check_reset_values();
        rst = 1'b0;
        repeat (row_delay[r]) step();
        for (int b = 0; b < row_bounce[r]; b++) begin
            blen  = 1 + take_bits(2);         // 1 to 4 cycles each way
            btn_n = 1'b0;
            repeat (blen) step();
            btn_n = 1'b1;
            repeat (blen) step();
        end
        btn_n = 1'b0;                         // steady press
        repeat (row_hold[r]) step();
        btn_n = 1'b1;
        for (int w = 0; w < WINDOW; w++) begin
            if (row_rst_at[r] != 0 && w == row_rst_at[r]) begin
                rst = 1'b1;
                @(posedge clk);
                @(negedge clk);
                check_reset_values();         // reset values one edge after rst
                step();
                rst = 1'b0;
            end else begin
                step();
            end
        end
        // two pulses, high nybble first, rs at both
        if (rise_data.size() != 2) report_value("E pulse count", 2, rise_data.size());
        for (int i = 0; i < rise_data.size() && i < 2; i++) begin
            exp_nyb = (i == 0) ? TEST_BYTE[7:4] : TEST_BYTE[3:0];
            if (rise_data[i] !== exp_nyb) report_value("nybble", exp_nyb, rise_data[i]);
            if (rise_rs[i] !== TEST_RS) report_value("rs", TEST_RS, rise_rs[i]);
        end
    endtask

    // hang guard
    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles > cycle_limit) begin
            $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst   = 1'b1;
        btn_n = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            cycle_limit += 8 + row_delay[r] + 8 * row_bounce[r] + row_hold[r] + WINDOW + 2;
        end
        cycle_limit += 50;                    // margin
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("done: %0d value errors, %0d other errors", val_errors, other_errors);
        if (val_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hd44780.f
hdl/hd44780_timing_pkg.sv
hdl/hd44780_board_pkg.sv
hdl/hd44780_nybble_sender.sv
hdl/hd44780_bytesender.sv
hdl/lcd_send_sequencer.sv
hdl/alive_blinker.sv
hdl/hd44780_top.sv
tb/tb_hd44780_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the HD44780 byte-sender testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f hd44780.f \
    --top-module tb_hd44780_top \
    -o sim_tb_hd44780

out=$(./obj_dir/sim_tb_hd44780)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi
